//--- Bender.yml
package:
  name: banked_spm

sources:
  - src/spm_pkg.sv
  - src/bank_req_if.sv
  - src/bank_rsp_if.sv
  - src/fair_arbiter.sv
  - src/core_req_dispatch.sv
  - src/spm_bank.sv
  - src/core_rsp_merge.sv
  - src/banked_spm.sv
  - target: test
    files:
      - dv/rsp_checker.sv
      - dv/tb_banked_spm.sv

//--- dv/rsp_checker.sv
module rsp_checker (
    input  logic                                       clk,
    input  logic                                       reset,
    input  spm_pkg::lane_mask_t                        core_req_valid,
    input  spm_pkg::lane_mask_t                        core_req_rw,
    input  spm_pkg::addr_t [spm_pkg::num_requests-1:0] core_req_addr,
    input  spm_pkg::word_t [spm_pkg::num_requests-1:0] core_req_data,
    input  spm_pkg::tag_t                              core_req_tag,
    input  logic                                       core_req_ready,
    input  spm_pkg::lane_mask_t                        core_rsp_valid,
    input  spm_pkg::word_t [spm_pkg::num_requests-1:0] core_rsp_data,
    input  spm_pkg::tag_t                              core_rsp_tag,
    input  logic                                       core_rsp_ready
);

    localparam int num_ids   = 2 ** spm_pkg::tag_id_bits;
    localparam int age_limit = 400;  // Cycles a read request may stay open

    spm_pkg::word_t      model    [2 ** spm_pkg::addr_width];
    spm_pkg::lane_mask_t exp_mask [num_ids] = '{default: '0};  // Read lanes still owed
    spm_pkg::word_t      exp_data [num_ids][spm_pkg::num_requests];
    spm_pkg::tag_t       exp_tag  [num_ids];
    int                  age      [num_ids];
    int                  err_base [num_ids];

    int   error_count = 0;
    int   done_count  = 0;
    int   open_count  = 0;
    logic reset_d     = 1'b1;
    logic req_busy    = 1'b0;  // Current request already seen on an earlier edge

    task automatic record_request();
        int id;
        id = int'(core_req_tag[spm_pkg::tag_id_bits-1:0]);
        if ((core_req_valid & ~core_req_rw) != '0) begin
            if (exp_mask[id] != '0) begin
                $display("tag id %0h reused while its request is still open", id);
                error_count++;
            end else begin
                open_count++;
            end
            exp_mask[id] = core_req_valid & ~core_req_rw;
            exp_tag[id]  = core_req_tag;
            age[id]      = 0;
            err_base[id] = error_count;
            for (int l = 0; l < spm_pkg::num_requests; l++) begin
                exp_data[id][l] = model[core_req_addr[l]];
            end
        end
        // Reads above saw the state before this request's writes
        for (int l = 0; l < spm_pkg::num_requests; l++) begin
            if (core_req_valid[l] && core_req_rw[l]) begin
                model[core_req_addr[l]] = core_req_data[l];
            end
        end
    endtask

    task automatic check_beat();
        int id;
        id = int'(core_rsp_tag[spm_pkg::tag_id_bits-1:0]);
        if (exp_mask[id] == '0) begin
            $display("response beat with tag %h belongs to no open request", core_rsp_tag);
            error_count++;
            return;
        end
        if (core_rsp_tag !== exp_tag[id]) begin
            $display("[ERROR] core_rsp_tag: expected %h, got %h", exp_tag[id], core_rsp_tag);
            error_count++;
        end
        for (int l = 0; l < spm_pkg::num_requests; l++) begin
            if (core_rsp_valid[l] && !exp_mask[id][l]) begin
                $display("lane %0d of tag %h returned twice or never requested", l, core_rsp_tag);
                error_count++;
            end else if (core_rsp_valid[l]) begin
                if (core_rsp_data[l] !== exp_data[id][l]) begin
                    $display("[ERROR] core_rsp_data[%0d] tag %h: expected %h, got %h",
                             l, core_rsp_tag, exp_data[id][l], core_rsp_data[l]);
                    error_count++;
                end
                exp_mask[id][l] = 1'b0;
            end
        end
        if (exp_mask[id] == '0) begin
            $display("request tag %h: reads complete, %s", exp_tag[id],
                     (error_count > err_base[id]) ? "with mismatches" : "ok");
            done_count++;
            open_count--;
        end
    endtask

    always @(posedge clk) begin
        if (reset_d && !reset && core_rsp_valid !== '0) begin
            $display("[ERROR] core_rsp_valid after reset: expected 0, got %h", core_rsp_valid);
            error_count++;
        end
        reset_d = reset;
        if (!reset) begin
            // An idle core must never be stalled
            if (core_req_valid == '0 && core_req_ready !== 1'b1) begin
                $display("[ERROR] core_req_ready while idle: expected 1, got %h", core_req_ready);
                error_count++;
            end
            if (core_rsp_ready && core_rsp_valid != '0) begin
                check_beat();
            end
            // Lanes on free banks issue before the retiring edge
            if (core_req_valid != '0 && !req_busy) begin
                record_request();
            end
            if (core_req_valid != '0 && core_req_ready &&
                (core_req_valid & ~core_req_rw) == '0) begin
                $display("request tag %h: writes only, retired", core_req_tag);
                done_count++;
            end
            req_busy = (core_req_valid != '0) && !core_req_ready;
            for (int i = 0; i < num_ids; i++) begin
                if (exp_mask[i] != '0) begin
                    age[i]++;
                    if (age[i] > age_limit) begin
                        $display("request tag %h never completed, lanes %b missing",
                                 exp_tag[i], exp_mask[i]);
                        error_count++;
                        exp_mask[i] = '0;
                        open_count--;
                    end
                end
            end
        end
    end

endmodule

//--- dv/tb_banked_spm.sv
module tb_banked_spm;

    localparam int num_entries   = 12;
    localparam int req_timeout   = 200;
    localparam int drain_timeout = 2000;

    logic                                       clk;
    logic                                       reset;
    spm_pkg::lane_mask_t                        core_req_valid;
    spm_pkg::lane_mask_t                        core_req_rw;
    spm_pkg::addr_t [spm_pkg::num_requests-1:0] core_req_addr;
    spm_pkg::word_t [spm_pkg::num_requests-1:0] core_req_data;
    spm_pkg::tag_t                              core_req_tag;
    logic                                       core_req_ready;
    spm_pkg::lane_mask_t                        core_rsp_valid;
    spm_pkg::word_t [spm_pkg::num_requests-1:0] core_rsp_data;
    spm_pkg::tag_t                              core_rsp_tag;
    logic                                       core_rsp_ready;

    // Stimulus table with one core request per row
    spm_pkg::lane_mask_t                        tbl_valid [num_entries];
    spm_pkg::lane_mask_t                        tbl_rw    [num_entries];
    spm_pkg::addr_t [spm_pkg::num_requests-1:0] tbl_addr  [num_entries];
    spm_pkg::word_t [spm_pkg::num_requests-1:0] tbl_data  [num_entries];
    spm_pkg::tag_t                              tbl_tag   [num_entries];
    int                                         n_entries = 0;

    logic [31:0] rnd_state = 32'ha09919ac;
    logic        bp_on     = 1'b0;
    logic        timed_out = 1'b0;

    banked_spm i_dut (.*);

    rsp_checker i_chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_entry(input spm_pkg::lane_mask_t v, input spm_pkg::lane_mask_t rw,
                             input spm_pkg::addr_t [spm_pkg::num_requests-1:0] a,
                             input spm_pkg::word_t [spm_pkg::num_requests-1:0] d,
                             input spm_pkg::tag_t t);
        tbl_valid[n_entries] = v;
        tbl_rw[n_entries]    = rw;
        tbl_addr[n_entries]  = a;
        tbl_data[n_entries]  = d;
        tbl_tag[n_entries]   = t;
        n_entries++;
    endtask

    // Lanes run 3 down to 0 and a set rw bit writes
    task automatic fill_table();
        add_entry(4'hf, 4'hf, {10'h013, 10'h012, 10'h011, 10'h010},
                  {32'hd0d0_0013, 32'hc0c0_0012, 32'hb0b0_0011, 32'ha0a0_0010}, 8'h10);
        add_entry(4'hf, 4'h0, {10'h013, 10'h012, 10'h011, 10'h010}, '0, 8'h21);
        add_entry(4'hf, 4'hf, {10'h02c, 10'h028, 10'h024, 10'h020},
                  {32'h2c2c_0003, 32'h2828_0002, 32'h2424_0001, 32'h2020_0000}, 8'h32);
        add_entry(4'hf, 4'h0, {10'h02c, 10'h028, 10'h024, 10'h020}, '0, 8'h43);
        add_entry(4'hf, 4'h5, {10'h024, 10'h032, 10'h011, 10'h030},
                  {32'h0, 32'h3232_5a5a, 32'h0, 32'h3030_a5a5}, 8'h54);
        add_entry(4'h3, 4'h0, {10'h000, 10'h000, 10'h032, 10'h030}, '0, 8'h65);
        add_entry(4'ha, 4'h0, {10'h02c, 10'h000, 10'h012, 10'h000}, '0, 8'h76);
        add_entry(4'hf, 4'h0, {10'h024, 10'h011, 10'h020, 10'h010}, '0, 8'h87);
        add_entry(4'hf, 4'hf, {10'h043, 10'h042, 10'h041, 10'h040},
                  {32'h4343_0f0f, 32'h4242_f0f0, 32'h4141_3c3c, 32'h4040_c3c3}, 8'h98);
        add_entry(4'hf, 4'h0, {10'h040, 10'h041, 10'h042, 10'h043}, '0, 8'ha9);
        add_entry(4'hf, 4'h0, {10'h041, 10'h011, 10'h041, 10'h011}, '0, 8'hba);
        add_entry(4'hf, 4'h0, {10'h042, 10'h030, 10'h013, 10'h028}, '0, 8'hcb);
    endtask

    task automatic wait_req_ready(input int i);
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!core_req_ready && t < req_timeout);
        if (!core_req_ready) begin
            $display("request %0d was not accepted within %0d cycles", i, req_timeout);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (i_chk.open_count != 0 && t < drain_timeout);
        if (i_chk.open_count != 0) begin
            $display("%0d read requests still open after %0d cycles",
                     i_chk.open_count, drain_timeout);
            timed_out = 1'b1;
        end
    endtask

    // Random back-pressure once bp_on is set
    always @(posedge clk) begin
        if (bp_on) begin
            rnd_state = xorshift(rnd_state);
            core_rsp_ready <= rnd_state[7];
        end else begin
            core_rsp_ready <= 1'b1;
        end
    end

    initial begin
        reset          = 1'b1;
        core_req_valid = '0;
        core_req_rw    = '0;
        core_req_addr  = '0;
        core_req_data  = '0;
        core_req_tag   = '0;
        core_rsp_ready = 1'b1;
        fill_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);  // One idle cycle
        for (int i = 0; i < n_entries && !timed_out; i++) begin
            if (i == 8) begin
                bp_on <= 1'b1;
            end
            core_req_valid <= tbl_valid[i];
            core_req_rw    <= tbl_rw[i];
            core_req_addr  <= tbl_addr[i];
            core_req_data  <= tbl_data[i];
            core_req_tag   <= tbl_tag[i];
            wait_req_ready(i);
        end
        core_req_valid <= '0;
        if (!timed_out) begin
            wait_drain();
        end
        $display("requests finished: %0d, errors: %0d", i_chk.done_count, i_chk.error_count);
        if (!timed_out && i_chk.error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
src/spm_pkg.sv
src/bank_req_if.sv
src/bank_rsp_if.sv
src/fair_arbiter.sv
src/core_req_dispatch.sv
src/spm_bank.sv
src/core_rsp_merge.sv
src/banked_spm.sv
dv/rsp_checker.sv
dv/tb_banked_spm.sv

//--- src/bank_req_if.sv
interface bank_req_if;

    logic               valid;
    logic               rw;     // 1 = write
    spm_pkg::row_t      row;
    spm_pkg::word_t     data;
    spm_pkg::lane_idx_t tid;    // Originating lane
    spm_pkg::tag_t      tag;
    logic               ready;

    modport dispatch (
        output valid, rw, row, data, tid, tag,
        input  ready
    );

    modport bank (
        input  valid, rw, row, data, tid, tag,
        output ready
    );

endinterface

//--- src/bank_rsp_if.sv
interface bank_rsp_if;

    // Queue head of one bank
    logic               valid;
    spm_pkg::word_t     data;
    spm_pkg::lane_idx_t tid;
    spm_pkg::tag_t      tag;
    logic               ready;  // Pops the head

    modport bank (
        output valid, data, tid, tag,
        input  ready
    );

    modport merge (
        input  valid, data, tid, tag,
        output ready
    );

endinterface

//--- src/banked_spm.sv
module banked_spm (
    input  logic                                         clk,
    input  logic                                         reset,
    input  spm_pkg::lane_mask_t                          core_req_valid,
    input  spm_pkg::lane_mask_t                          core_req_rw,
    input  spm_pkg::addr_t [spm_pkg::num_requests-1:0]   core_req_addr,
    input  spm_pkg::word_t [spm_pkg::num_requests-1:0]   core_req_data,
    input  spm_pkg::tag_t                                core_req_tag,
    output logic                                         core_req_ready,
    output spm_pkg::lane_mask_t                          core_rsp_valid,
    output spm_pkg::word_t [spm_pkg::num_requests-1:0]   core_rsp_data,
    output spm_pkg::tag_t                                core_rsp_tag,
    input  logic                                         core_rsp_ready
);

    bank_req_if bank_req [spm_pkg::num_banks] ();
    bank_rsp_if bank_rsp [spm_pkg::num_banks] ();

    core_req_dispatch i_dispatch (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (core_req_valid),
        .core_req_rw    (core_req_rw),
        .core_req_addr  (core_req_addr),
        .core_req_data  (core_req_data),
        .core_req_tag   (core_req_tag),
        .core_req_ready (core_req_ready),
        .bank_req       (bank_req)
    );

    for (genvar b = 0; b < spm_pkg::num_banks; b++) begin : g_bank
        spm_bank i_bank (
            .clk   (clk),
            .reset (reset),
            .req   (bank_req[b]),
            .rsp   (bank_rsp[b])
        );
    end

    core_rsp_merge i_merge (
        .clk            (clk),
        .reset          (reset),
        .bank_rsp       (bank_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_data  (core_rsp_data),
        .core_rsp_tag   (core_rsp_tag),
        .core_rsp_ready (core_rsp_ready)
    );

endmodule

//--- src/core_req_dispatch.sv
module core_req_dispatch (
    input  logic                                         clk,
    input  logic                                         reset,
    input  spm_pkg::lane_mask_t                          core_req_valid,
    input  spm_pkg::lane_mask_t                          core_req_rw,
    input  spm_pkg::addr_t [spm_pkg::num_requests-1:0]   core_req_addr,
    input  spm_pkg::word_t [spm_pkg::num_requests-1:0]   core_req_data,
    input  spm_pkg::tag_t                                core_req_tag,
    output logic                                         core_req_ready,
    bank_req_if.dispatch                                 bank_req [spm_pkg::num_banks]
);

    spm_pkg::lane_mask_t           issued;   // Lanes already sent for this request
    spm_pkg::lane_mask_t           pending;
    spm_pkg::lane_mask_t           fire;     // Lanes accepted this cycle
    logic [spm_pkg::num_banks-1:0] bank_hit;
    logic [spm_pkg::num_banks-1:0] bank_rdy;
    spm_pkg::lane_idx_t            bank_lane [spm_pkg::num_banks];

    assign pending = core_req_valid & ~issued;

    always_comb begin
        fire = '0;
        for (int b = 0; b < spm_pkg::num_banks; b++) begin
            bank_hit[b]  = 1'b0;
            bank_lane[b] = '0;
            // Lowest pending lane on this bank wins, others wait
            for (int l = spm_pkg::num_requests - 1; l >= 0; l--) begin
                if (pending[l] &&
                    core_req_addr[l][spm_pkg::bank_bits-1:0] == spm_pkg::bank_idx_t'(b)) begin
                    bank_hit[b]  = 1'b1;
                    bank_lane[b] = spm_pkg::lane_idx_t'(l);
                end
            end
            if (bank_hit[b] && bank_rdy[b]) begin
                fire[bank_lane[b]] = 1'b1;
            end
        end
    end

    // Retire once nothing is left over after this cycle
    assign core_req_ready = ((pending & ~fire) == '0);

    for (genvar b = 0; b < spm_pkg::num_banks; b++) begin : g_bank
        assign bank_rdy[b]       = bank_req[b].ready;
        assign bank_req[b].valid = bank_hit[b];
        assign bank_req[b].rw    = core_req_rw[bank_lane[b]];
        assign bank_req[b].row   =
            core_req_addr[bank_lane[b]][spm_pkg::addr_width-1:spm_pkg::bank_bits];
        assign bank_req[b].data  = core_req_data[bank_lane[b]];
        assign bank_req[b].tid   = bank_lane[b];
        assign bank_req[b].tag   = core_req_tag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issued <= '0;
        end else if (core_req_ready) begin
            issued <= '0;  // Next request starts clean
        end else begin
            issued <= issued | fire;
        end
    end

endmodule

//--- src/core_rsp_merge.sv
module core_rsp_merge (
    input  logic                                         clk,
    input  logic                                         reset,
    bank_rsp_if.merge                                    bank_rsp [spm_pkg::num_banks],
    output spm_pkg::lane_mask_t                          core_rsp_valid,
    output spm_pkg::word_t [spm_pkg::num_requests-1:0]   core_rsp_data,
    output spm_pkg::tag_t                                core_rsp_tag,
    input  logic                                         core_rsp_ready
);

    logic [spm_pkg::num_banks-1:0] head_valid;
    logic [spm_pkg::num_banks-1:0] head_match;  // Heads joining this beat
    spm_pkg::word_t                head_data [spm_pkg::num_banks];
    spm_pkg::lane_idx_t            head_tid  [spm_pkg::num_banks];
    spm_pkg::tag_t                 head_tag  [spm_pkg::num_banks];

    spm_pkg::bank_idx_t            main_bank;
    logic                          main_valid;

    fair_arbiter i_sel_bank (
        .clk         (clk),
        .reset       (reset),
        .requests    (head_valid),
        .advance     (core_rsp_ready),
        .grant_index (main_bank),
        .grant_valid (main_valid)
    );

    for (genvar b = 0; b < spm_pkg::num_banks; b++) begin : g_bank
        assign head_valid[b]     = bank_rsp[b].valid;
        assign head_data[b]      = bank_rsp[b].data;
        assign head_tid[b]       = bank_rsp[b].tid;
        assign head_tag[b]       = bank_rsp[b].tag;
        assign bank_rsp[b].ready = head_match[b] && core_rsp_ready;
    end

    assign core_rsp_tag = head_tag[main_bank];

    always_comb begin
        core_rsp_valid = '0;
        core_rsp_data  = '0;
        for (int b = 0; b < spm_pkg::num_banks; b++) begin
            // Same request id as the granted head
            head_match[b] = main_valid && head_valid[b] &&
                (head_tag[b][spm_pkg::tag_id_bits-1:0] ==
                 head_tag[main_bank][spm_pkg::tag_id_bits-1:0]);
            if (head_match[b]) begin
                core_rsp_valid[head_tid[b]] = 1'b1;
                core_rsp_data[head_tid[b]]  = head_data[b];
            end
        end
    end

endmodule

//--- src/fair_arbiter.sv
module fair_arbiter (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [spm_pkg::num_banks-1:0] requests,
    input  logic                          advance,
    output spm_pkg::bank_idx_t            grant_index,
    output logic                          grant_valid
);

    spm_pkg::bank_idx_t ptr;  // Highest priority bank
    spm_pkg::bank_idx_t idx;

    // Scan from the far end so the first requester at or after ptr wins
    always_comb begin
        grant_valid = 1'b0;
        grant_index = ptr;
        idx         = ptr;
        for (int i = spm_pkg::num_banks - 1; i >= 0; i--) begin
            idx = ptr + spm_pkg::bank_idx_t'(i);  // Wraps with the index width
            if (requests[idx]) begin
                grant_valid = 1'b1;
                grant_index = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (advance && grant_valid) begin
            ptr <= grant_index + 1'b1;  // Granted bank drops to lowest priority
        end
    end

endmodule

//--- src/spm_bank.sv
module spm_bank (
    input  logic       clk,
    input  logic       reset,
    bank_req_if.bank   req,
    bank_rsp_if.bank   rsp
);

    spm_pkg::word_t mem [spm_pkg::bank_depth];

    // Two-entry response queue
    spm_pkg::word_t     q_data [2];
    spm_pkg::lane_idx_t q_tid  [2];
    spm_pkg::tag_t      q_tag  [2];
    logic               wr_ptr;
    logic               rd_ptr;
    logic [1:0]         count;

    logic               fire;
    logic               push;
    logic               pop;

    assign pop  = rsp.valid && rsp.ready;
    assign fire = req.valid && req.ready;
    assign push = fire && !req.rw;  // Only reads answer

    // A pop frees the slot in the same edge
    assign req.ready = (count != 2'd2) || pop;

    always_ff @(posedge clk) begin
        if (fire && req.rw) begin
            mem[req.row] <= req.data;
        end
        if (push) begin
            q_data[wr_ptr] <= mem[req.row];
            q_tid[wr_ptr]  <= req.tid;
            q_tag[wr_ptr]  <= req.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    assign rsp.valid = (count != '0);
    assign rsp.data  = q_data[rd_ptr];
    assign rsp.tid   = q_tid[rd_ptr];
    assign rsp.tag   = q_tag[rd_ptr];

endmodule

//--- src/spm_pkg.sv
package spm_pkg;

    // Lane and bank counts
    localparam int num_banks    = 4;
    localparam int num_requests = 4;
    localparam int bank_bits    = 2;  // log2(num_banks)
    localparam int reqs_bits    = 2;  // log2(num_requests)

    localparam int word_width   = 32;

    // Word address, low bank_bits pick the bank
    localparam int addr_width   = 10;
    localparam int bank_depth   = 256;  // 2**(addr_width-bank_bits)

    localparam int tag_width    = 8;
    localparam int tag_id_bits  = 4;  // Low tag bits naming an outstanding request

    typedef logic [word_width-1:0]           word_t;
    typedef logic [addr_width-1:0]           addr_t;
    typedef logic [addr_width-bank_bits-1:0] row_t;
    typedef logic [tag_width-1:0]            tag_t;
    typedef logic [bank_bits-1:0]            bank_idx_t;
    typedef logic [reqs_bits-1:0]            lane_idx_t;
    typedef logic [num_requests-1:0]         lane_mask_t;

endpackage
